//--- source/spi_hub_pkg.sv
package spi_hub_pkg;

  // port count, 1 to 8 ports supported
  localparam int NUM_PORTS = 4;
  localparam int PORT_W    = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

  // SPI word, always four bytes MSB first
  localparam int WORD_W = 32;

  // rx fifo sizing
  localparam int RX_DEPTH = 8;
  localparam int RX_PTR_W = (RX_DEPTH > 1) ? $clog2(RX_DEPTH) : 1;
  localparam int LEVEL_W  = $clog2(RX_DEPTH + 1);  // level counts 0..RX_DEPTH

  // apb address width, byte addressed
  localparam int APB_ADDR_W = 8;

  // register map
  localparam logic [APB_ADDR_W-1:0] ADDR_CTRL    = 8'h00;  // per-port enables
  localparam logic [APB_ADDR_W-1:0] ADDR_STATUS  = 8'h04;  // level, pending, overrun
  localparam logic [APB_ADDR_W-1:0] ADDR_RX_DATA = 8'h08;  // read pops one word
  localparam logic [APB_ADDR_W-1:0] ADDR_RX_PORT = 8'h0C;  // source of last pop
  localparam logic [APB_ADDR_W-1:0] ADDR_TX_BASE = 8'h10;  // TX_WORD[i] at base + 4*i

  // first address past the TX_WORD block
  localparam logic [APB_ADDR_W-1:0] ADDR_TX_END =
    ADDR_TX_BASE + APB_ADDR_W'(4 * NUM_PORTS);

  // STATUS field positions
  // level sits at bit 0, LEVEL_W bits wide
  localparam int STAT_PEND_LSB = 8;   // tx word pending, one bit per port
  localparam int STAT_OVR_LSB  = 16;  // sticky overrun, write one to clear

endpackage

//--- source/spi_slave_port.sv
`timescale 1ns/1ps

module spi_slave_port (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             enable,
  input  logic                             sck,
  input  logic                             ssel,
  input  logic                             mosi,
  output logic                             miso,
  input  logic [spi_hub_pkg::WORD_W-1:0]   tx_word,
  input  logic                             tx_pending,
  output logic                             tx_taken,
  output logic                             word_valid,
  output logic [spi_hub_pkg::WORD_W-1:0]   word_data,
  input  logic                             word_ready,
  output logic                             overrun
);

  logic [2:0]                     sck_q;   // two sync stages plus edge detect
  logic [2:0]                     ssel_q;
  logic [1:0]                     mosi_q;
  logic                           sck_rise;
  logic                           sck_fall;
  logic                           ssel_fall;
  logic                           in_frame;
  logic [2:0]                     bit_cnt;
  logic [1:0]                     byte_cnt;
  logic                           rx_done;
  logic                           word_end;
  logic [spi_hub_pkg::WORD_W-1:0] rx_shift;
  logic [spi_hub_pkg::WORD_W-1:0] tx_shift;
  logic                           tx_load;
  logic                           hold_load;
  logic                           accept;

  // bring the pins into the clk domain
  always_ff @(posedge clk) begin
    if (rst) begin
      sck_q  <= '0;
      ssel_q <= '1;  // deselected
      mosi_q <= '0;
    end else begin
      sck_q  <= {sck_q[1:0], sck};
      ssel_q <= {ssel_q[1:0], ssel};
      mosi_q <= {mosi_q[0], mosi};
    end
  end

  assign sck_rise  = sck_q[1] & ~sck_q[2];
  assign sck_fall  = ~sck_q[1] & sck_q[2];
  assign ssel_fall = enable & ssel_q[2] & ~ssel_q[1];  // disabled port ignores ssel

  // frame is open from ssel falling edge until ssel goes high again
  always_ff @(posedge clk) begin
    if (rst) begin
      in_frame <= 1'b0;
    end else if (!enable || ssel_q[1]) begin
      in_frame <= 1'b0;
    end else if (ssel_fall) begin
      in_frame <= 1'b1;
    end
  end

  // bit and byte counters, a partial word is lost when the frame closes
  always_ff @(posedge clk) begin
    if (rst) begin
      bit_cnt  <= '0;
      byte_cnt <= '0;
      rx_done  <= 1'b0;
      word_end <= 1'b0;
    end else begin
      rx_done <= 1'b0;
      if (!in_frame) begin
        bit_cnt  <= '0;
        byte_cnt <= '0;
        word_end <= 1'b0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        if (bit_cnt == 3'd7) begin
          byte_cnt <= byte_cnt + 2'd1;
          if (byte_cnt == 2'd3) begin
            rx_done  <= 1'b1;  // 32nd bit just shifted in
            word_end <= 1'b1;
          end
        end
      end else if (sck_fall) begin
        word_end <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_frame && sck_rise) begin
      rx_shift <= {rx_shift[spi_hub_pkg::WORD_W-2:0], mosi_q[1]};  // msb first
    end
  end

  // new tx word at frame start or on the falling edge after bit 32
  assign tx_load  = ssel_fall | (in_frame & sck_fall & word_end);
  assign tx_taken = tx_load;

  always_ff @(posedge clk) begin
    if (tx_load) begin
      tx_shift <= tx_pending ? tx_word : '0;
    end else if (in_frame && sck_fall) begin
      tx_shift <= {tx_shift[spi_hub_pkg::WORD_W-2:0], 1'b0};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      miso <= 1'b0;
    end else begin
      miso <= enable & in_frame & tx_shift[spi_hub_pkg::WORD_W-1];
    end
  end

  // holding register toward the collector
  assign accept    = word_valid & word_ready;
  assign hold_load = rx_done & (~word_valid | word_ready);
  assign overrun   = rx_done & word_valid & ~word_ready;  // new word dropped

  always_ff @(posedge clk) begin
    if (rst) begin
      word_valid <= 1'b0;
    end else if (hold_load) begin
      word_valid <= 1'b1;
    end else if (accept) begin
      word_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (hold_load) begin
      word_data <= rx_shift;
    end
  end

  a_hold_stable: assert property (@(posedge clk) disable iff (rst)
    word_valid && !word_ready |=> word_valid && $stable(word_data))
    else $error("word_data changed before the collector took it");

  a_taken_pulse: assert property (@(posedge clk) disable iff (rst)
    tx_taken |=> !tx_taken)
    else $error("tx_taken held for more than one cycle");

endmodule

//--- source/spi_apb_regs.sv
`timescale 1ns/1ps

module spi_apb_regs (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [spi_hub_pkg::APB_ADDR_W-1:0]  paddr,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [31:0]                         pwdata,
  output logic [31:0]                         prdata,
  output logic                                pready,
  output logic                                pslverr,
  output logic [spi_hub_pkg::NUM_PORTS-1:0]   enable,
  output logic [spi_hub_pkg::WORD_W-1:0]      tx_word [spi_hub_pkg::NUM_PORTS],
  output logic [spi_hub_pkg::NUM_PORTS-1:0]   tx_pending,
  input  logic [spi_hub_pkg::NUM_PORTS-1:0]   tx_taken,
  input  logic [spi_hub_pkg::NUM_PORTS-1:0]   overrun,
  input  logic [spi_hub_pkg::LEVEL_W-1:0]     rx_level,
  input  logic [spi_hub_pkg::WORD_W-1:0]      rx_data,
  input  logic [spi_hub_pkg::PORT_W-1:0]      rx_port,
  output logic                                rx_pop
);

  logic                                access;
  logic                                wr_en;
  logic                                rd_first;  // first cycle of an RX_DATA read
  logic                                sel_ctrl;
  logic                                sel_status;
  logic                                sel_rxdata;
  logic                                sel_rxport;
  logic                                sel_tx;
  logic                                mapped;
  logic [spi_hub_pkg::APB_ADDR_W-1:0]  tx_off;
  logic [spi_hub_pkg::PORT_W-1:0]      tx_idx;
  logic                                rd_wait;
  logic                                rd_err;
  logic [spi_hub_pkg::WORD_W-1:0]      rd_data;
  logic [spi_hub_pkg::PORT_W-1:0]      last_port;
  logic [spi_hub_pkg::NUM_PORTS-1:0]   ovr;
  logic [31:0]                         status;

  // address decode
  assign sel_ctrl   = paddr == spi_hub_pkg::ADDR_CTRL;
  assign sel_status = paddr == spi_hub_pkg::ADDR_STATUS;
  assign sel_rxdata = paddr == spi_hub_pkg::ADDR_RX_DATA;
  assign sel_rxport = paddr == spi_hub_pkg::ADDR_RX_PORT;
  assign sel_tx     = (paddr >= spi_hub_pkg::ADDR_TX_BASE) &&
                      (paddr < spi_hub_pkg::ADDR_TX_END) && (paddr[1:0] == 2'b00);
  assign mapped     = sel_ctrl | sel_status | sel_rxdata | sel_rxport | sel_tx;
  assign tx_off     = paddr - spi_hub_pkg::ADDR_TX_BASE;
  assign tx_idx     = tx_off[2 +: spi_hub_pkg::PORT_W];

  assign access   = psel & penable;
  assign wr_en    = access & pwrite;
  assign rd_first = access & ~pwrite & sel_rxdata & ~rd_wait;
  assign pready   = access & ~rd_first;  // one wait state on RX_DATA reads only
  assign rx_pop   = rd_first & (rx_level != '0);

  // capture the fifo head during the wait cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_wait   <= 1'b0;
      rd_err    <= 1'b0;
      last_port <= '0;
    end else begin
      rd_wait <= rd_first;
      if (rd_first) begin
        rd_err <= rx_level == '0;  // empty pop
      end
      if (rx_pop) begin
        last_port <= rx_port;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_pop) begin
      rd_data <= rx_data;
    end
  end

  always_comb begin
    status = '0;
    status[spi_hub_pkg::LEVEL_W-1:0]                            = rx_level;
    status[spi_hub_pkg::STAT_PEND_LSB +: spi_hub_pkg::NUM_PORTS] = tx_pending;
    status[spi_hub_pkg::STAT_OVR_LSB +: spi_hub_pkg::NUM_PORTS]  = ovr;
  end

  // read data and error, only valid in the completing cycle
  always_comb begin
    prdata  = '0;
    pslverr = 1'b0;
    if (pready) begin
      if (!mapped) begin
        pslverr = 1'b1;
      end else if (!pwrite) begin
        if (sel_ctrl) begin
          prdata[spi_hub_pkg::NUM_PORTS-1:0] = enable;
        end else if (sel_status) begin
          prdata = status;
        end else if (sel_rxdata) begin
          pslverr = rd_err;
          prdata  = rd_err ? '0 : rd_data;
        end else if (sel_rxport) begin
          prdata[spi_hub_pkg::PORT_W-1:0] = last_port;
        end else begin
          prdata = tx_word[tx_idx];
        end
      end
    end
  end

  // control and sticky bits, a cpu write beats a same-cycle clear
  always_ff @(posedge clk) begin
    if (rst) begin
      enable     <= '0;
      tx_pending <= '0;
      ovr        <= '0;
    end else begin
      if (wr_en && sel_ctrl) begin
        enable <= pwdata[spi_hub_pkg::NUM_PORTS-1:0];
      end
      for (int i = 0; i < spi_hub_pkg::NUM_PORTS; i++) begin
        if (wr_en && sel_tx && tx_idx == spi_hub_pkg::PORT_W'(i)) begin
          tx_pending[i] <= 1'b1;
        end else if (tx_taken[i]) begin
          tx_pending[i] <= 1'b0;
        end
        if (overrun[i]) begin
          ovr[i] <= 1'b1;  // a new overrun wins over the clear
        end else if (wr_en && sel_status && pwdata[spi_hub_pkg::STAT_OVR_LSB + i]) begin
          ovr[i] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en && sel_tx) begin
      tx_word[tx_idx] <= pwdata;
    end
  end

  a_pop_then_done: assert property (@(posedge clk) disable iff (rst)
    rx_pop |-> (rx_level != '0) ##1 pready)
    else $error("pop on empty fifo or read not completed after wait cycle");

endmodule

//--- source/spi_rx_collector.sv
`timescale 1ns/1ps

module spi_rx_collector (
  input  logic                               clk,
  input  logic                               rst,
  input  logic [spi_hub_pkg::NUM_PORTS-1:0]  word_valid,
  input  logic [spi_hub_pkg::WORD_W-1:0]     word_data [spi_hub_pkg::NUM_PORTS],
  output logic [spi_hub_pkg::NUM_PORTS-1:0]  word_ready,
  input  logic                               rx_pop,
  output logic [spi_hub_pkg::LEVEL_W-1:0]    rx_level,
  output logic [spi_hub_pkg::WORD_W-1:0]     rx_data,
  output logic [spi_hub_pkg::PORT_W-1:0]     rx_port
);

  logic [spi_hub_pkg::WORD_W-1:0]    mem_data [spi_hub_pkg::RX_DEPTH];
  logic [spi_hub_pkg::PORT_W-1:0]    mem_port [spi_hub_pkg::RX_DEPTH];
  logic [spi_hub_pkg::RX_PTR_W-1:0]  wr_ptr;
  logic [spi_hub_pkg::RX_PTR_W-1:0]  rd_ptr;
  logic [spi_hub_pkg::LEVEL_W-1:0]   count;
  logic                              full;
  logic [spi_hub_pkg::PORT_W-1:0]    rr_ptr;  // first port to look at
  logic [spi_hub_pkg::NUM_PORTS-1:0] grant;
  logic [spi_hub_pkg::PORT_W-1:0]    gnt_idx;
  logic                              found;
  logic                              push;

  assign full = count == spi_hub_pkg::LEVEL_W'(spi_hub_pkg::RX_DEPTH);

  // round-robin search starting at rr_ptr
  always_comb begin : grant_search
    int cand;
    grant   = '0;
    gnt_idx = '0;
    found   = 1'b0;
    for (int i = 0; i < spi_hub_pkg::NUM_PORTS; i++) begin
      cand = (int'(rr_ptr) + i) % spi_hub_pkg::NUM_PORTS;
      if (!found && word_valid[cand]) begin
        found       = 1'b1;
        grant[cand] = 1'b1;
        gnt_idx     = spi_hub_pkg::PORT_W'(cand);
      end
    end
  end

  assign word_ready = full ? '0 : grant;  // back-pressure when full
  assign push       = found & ~full;

  always_ff @(posedge clk) begin
    if (rst) begin
      rr_ptr <= '0;
    end else if (push) begin
      if (gnt_idx == spi_hub_pkg::PORT_W'(spi_hub_pkg::NUM_PORTS - 1)) begin
        rr_ptr <= '0;
      end else begin
        rr_ptr <= gnt_idx + 1'b1;
      end
    end
  end

  // circular fifo of word plus source port
  always_ff @(posedge clk) begin
    if (push) begin
      mem_data[wr_ptr] <= word_data[gnt_idx];
      mem_port[wr_ptr] <= gnt_idx;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == spi_hub_pkg::RX_PTR_W'(spi_hub_pkg::RX_DEPTH - 1)) ?
                  '0 : wr_ptr + 1'b1;
      end
      if (rx_pop) begin
        rd_ptr <= (rd_ptr == spi_hub_pkg::RX_PTR_W'(spi_hub_pkg::RX_DEPTH - 1)) ?
                  '0 : rd_ptr + 1'b1;
      end
      if (push && !rx_pop) begin
        count <= count + 1'b1;
      end else if (rx_pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  assign rx_level = count;
  assign rx_data  = mem_data[rd_ptr];  // fifo head, valid while level is nonzero
  assign rx_port  = mem_port[rd_ptr];

  a_ready_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(word_ready))
    else $error("more than one port granted in a cycle");

  a_no_push_full: assert property (@(posedge clk) disable iff (rst)
    (|(word_ready & word_valid)) |-> count < spi_hub_pkg::LEVEL_W'(spi_hub_pkg::RX_DEPTH))
    else $error("word accepted into a full fifo");

endmodule

//--- source/spi_hub.sv
`timescale 1ns/1ps

module spi_hub (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [spi_hub_pkg::APB_ADDR_W-1:0]  paddr,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [31:0]                         pwdata,
  output logic [31:0]                         prdata,
  output logic                                pready,
  output logic                                pslverr,
  input  logic [spi_hub_pkg::NUM_PORTS-1:0]   sck,
  input  logic [spi_hub_pkg::NUM_PORTS-1:0]   ssel,  // active low
  input  logic [spi_hub_pkg::NUM_PORTS-1:0]   mosi,
  output logic [spi_hub_pkg::NUM_PORTS-1:0]   miso
);

  logic [spi_hub_pkg::NUM_PORTS-1:0] enable;
  logic [spi_hub_pkg::WORD_W-1:0]    tx_word [spi_hub_pkg::NUM_PORTS];
  logic [spi_hub_pkg::NUM_PORTS-1:0] tx_pending;
  logic [spi_hub_pkg::NUM_PORTS-1:0] tx_taken;
  logic [spi_hub_pkg::NUM_PORTS-1:0] overrun;
  logic [spi_hub_pkg::NUM_PORTS-1:0] word_valid;
  logic [spi_hub_pkg::WORD_W-1:0]    word_data [spi_hub_pkg::NUM_PORTS];
  logic [spi_hub_pkg::NUM_PORTS-1:0] word_ready;
  logic [spi_hub_pkg::LEVEL_W-1:0]   rx_level;
  logic [spi_hub_pkg::WORD_W-1:0]    rx_data;
  logic [spi_hub_pkg::PORT_W-1:0]    rx_port;
  logic                              rx_pop;

  spi_apb_regs u_regs (
    .clk        (clk),
    .rst        (rst),
    .paddr      (paddr),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .enable     (enable),
    .tx_word    (tx_word),
    .tx_pending (tx_pending),
    .tx_taken   (tx_taken),
    .overrun    (overrun),
    .rx_level   (rx_level),
    .rx_data    (rx_data),
    .rx_port    (rx_port),
    .rx_pop     (rx_pop)
  );

  for (genvar g = 0; g < spi_hub_pkg::NUM_PORTS; g++) begin : g_port
    spi_slave_port u_port (
      .clk        (clk),
      .rst        (rst),
      .enable     (enable[g]),
      .sck        (sck[g]),
      .ssel       (ssel[g]),
      .mosi       (mosi[g]),
      .miso       (miso[g]),
      .tx_word    (tx_word[g]),
      .tx_pending (tx_pending[g]),
      .tx_taken   (tx_taken[g]),
      .word_valid (word_valid[g]),
      .word_data  (word_data[g]),
      .word_ready (word_ready[g]),
      .overrun    (overrun[g])
    );
  end

  spi_rx_collector u_collector (
    .clk        (clk),
    .rst        (rst),
    .word_valid (word_valid),
    .word_data  (word_data),
    .word_ready (word_ready),
    .rx_pop     (rx_pop),
    .rx_level   (rx_level),
    .rx_data    (rx_data),
    .rx_port    (rx_port)
  );

endmodule

//--- sim/spi_hub_tb.sv
`timescale 1ns/1ps

module spi_hub_tb;

  localparam int NP       = spi_hub_pkg::NUM_PORTS;
  localparam int N_ROUNDS = 12;
  localparam int N_CUT    = 4;
  localparam int N_BP     = spi_hub_pkg::RX_DEPTH + 2;
  // worst case, concurrent transfers counted one after another
  localparam int MAX_BITS = N_ROUNDS * NP * 32 + NP * 2 * 32 + N_CUT * 63 + N_BP * 32;
  localparam int TIMEOUT_NS = 2 * MAX_BITS * 16 * 8;

  logic                               clk;
  logic                               rst;
  logic [spi_hub_pkg::APB_ADDR_W-1:0] paddr;
  logic                               psel;
  logic                               penable;
  logic                               pwrite;
  logic [31:0]                        pwdata;
  logic [31:0]                        prdata;
  logic                               pready;
  logic                               pslverr;
  logic [NP-1:0]                      sck;
  logic [NP-1:0]                      ssel;
  logic [NP-1:0]                      mosi;
  logic [NP-1:0]                      miso;

  int errors;
  int checks;

  // reference model
  logic [31:0]   exp_q [NP][$];  // words still to be popped, per port
  logic [31:0]   m_tx [NP];
  logic [NP-1:0] m_pend;
  logic [NP-1:0] m_en;
  logic [NP-1:0] m_ovr;

  spi_hub dut (
    .clk     (clk),
    .rst     (rst),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .sck     (sck),
    .ssel    (ssel),
    .mosi    (mosi),
    .miso    (miso)
  );

  always #4 clk = ~clk;

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic apb_access(input logic wr, input logic [spi_hub_pkg::APB_ADDR_W-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int waits;
    @(negedge clk);
    paddr   = addr;
    pwrite  = wr;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    waits   = 0;
    #1;
    while (!pready) begin  // rx data reads add a wait state
      waits++;
      @(negedge clk);
      #1;
    end
    rdata = prdata;
    err   = pslverr;
    // one wait state on RX_DATA reads, none anywhere else
    check(waits, (!wr && addr == spi_hub_pkg::ADDR_RX_DATA) ? 1 : 0, "APB wait states");
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [spi_hub_pkg::APB_ADDR_W-1:0] addr,
                           input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b1, addr, data, rdata, err);
    check(err, 0, "pslverr on write");
  endtask

  task automatic apb_read(input logic [spi_hub_pkg::APB_ADDR_W-1:0] addr,
                          output logic [31:0] data, output logic err);
    apb_access(1'b0, addr, '0, data, err);
  endtask

  // mode 0 master, mosi set while sck is low, miso sampled before the rising edge
  task automatic spi_xfer(input int port, input logic [31:0] word, input int nbits,
                          output logic [31:0] got);
    got = '0;
    @(negedge clk);
    ssel[port] = 1'b0;
    for (int b = 0; b < nbits; b++) begin
      mosi[port] = word[31 - b];
      repeat (5 + $urandom_range(3)) @(negedge clk);
      got = {got[30:0], miso[port]};
      sck[port] = 1'b1;
      repeat (5 + $urandom_range(3)) @(negedge clk);
      sck[port] = 1'b0;
    end
    repeat (5 + $urandom_range(3)) @(negedge clk);
    ssel[port] = 1'b1;
    mosi[port] = 1'b0;
    repeat (5 + $urandom_range(3)) @(negedge clk);
  endtask

  function automatic int queued_total();
    int n;
    n = 0;
    for (int p = 0; p < NP; p++) begin
      n += exp_q[p].size();
    end
    return n;
  endfunction

  function automatic logic [31:0] exp_status();
    logic [31:0] s;
    int          lvl;
    lvl = queued_total();
    if (lvl > spi_hub_pkg::RX_DEPTH) lvl = spi_hub_pkg::RX_DEPTH;  // rest held in a port
    s = '0;
    s[spi_hub_pkg::LEVEL_W-1:0] = spi_hub_pkg::LEVEL_W'(lvl);
    s[8 +: NP]  = m_pend;
    s[16 +: NP] = m_ovr;
    return s;
  endfunction

  task automatic send_word(input int port, input int nbits);
    logic [31:0] word;
    logic [31:0] got;
    logic [31:0] exp_miso;
    word     = $urandom;
    exp_miso = '0;
    if (m_en[port]) begin  // word start takes the pending tx word
      if (m_pend[port]) exp_miso = m_tx[port];
      m_pend[port] = 1'b0;
    end
    spi_xfer(port, word, nbits, got);
    check(got, exp_miso >> (32 - nbits), $sformatf("MISO bits on port %0d", port));
    if (m_en[port] && nbits == 32) begin
      if (queued_total() > spi_hub_pkg::RX_DEPTH) begin
        m_ovr[port] = 1'b1;  // fifo full and the port still holds a word
      end else begin
        exp_q[port].push_back(word);
      end
    end
  endtask

  task automatic set_enables(input logic [31:0] mask);
    logic [31:0] data;
    logic        err;
    apb_write(spi_hub_pkg::ADDR_CTRL, mask);
    m_en = mask[NP-1:0];
    apb_read(spi_hub_pkg::ADDR_CTRL, data, err);
    check(data, 32'(m_en), "CTRL readback");
  endtask

  task automatic drain_fifo();
    logic [31:0] data;
    logic [31:0] port_rd;
    logic        err;
    int          total;
    total = queued_total();
    apb_read(spi_hub_pkg::ADDR_STATUS, data, err);
    check(data, exp_status(), "STATUS before drain");
    for (int i = 0; i < total; i++) begin
      apb_read(spi_hub_pkg::ADDR_RX_DATA, data, err);
      check(err, 0, "pslverr on RX_DATA pop");
      apb_read(spi_hub_pkg::ADDR_RX_PORT, port_rd, err);
      if (port_rd >= NP || exp_q[port_rd].size() == 0) begin
        errors++;
        $display("Popped a word tagged with port %0d, which has no word outstanding",
                 port_rd);
      end else begin
        check(data, exp_q[port_rd].pop_front(), $sformatf("word from port %0d", port_rd));
      end
    end
    apb_read(spi_hub_pkg::ADDR_STATUS, data, err);
    check(data, exp_status(), "STATUS after drain");
  endtask

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("Errors found");
    $finish;
  end

  initial begin : stim
    logic [31:0] data;
    logic        err;
    logic [31:0] w;
    int          p;
    int          n;
    clk     = 1'b0;
    rst     = 1'b1;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    sck     = '0;
    ssel    = '1;  // all masters idle
    mosi    = '0;
    errors  = 0;
    checks  = 0;
    m_pend  = '0;
    m_en    = '0;
    m_ovr   = '0;
    void'($urandom(32'h3f99_a763));
    repeat (16) @(negedge clk);
    rst = 1'b0;
    repeat (4) @(negedge clk);

    // state after reset
    apb_read(spi_hub_pkg::ADDR_CTRL, data, err);
    check(data, 0, "CTRL after reset");
    apb_read(spi_hub_pkg::ADDR_STATUS, data, err);
    check(data, 0, "STATUS after reset");
    apb_read(spi_hub_pkg::ADDR_RX_DATA, data, err);
    check(err, 1, "pslverr on empty pop");
    check(data, 0, "data on empty pop");
    apb_read(8'h40, data, err);
    check(err, 1, "pslverr on unmapped address");

    // random words on random ports, several masters at once
    for (int r = 0; r < N_ROUNDS; r++) begin
      set_enables($urandom);
      for (int q = 0; q < NP; q++) begin
        automatic int port = q;
        if ($urandom_range(3) != 0) begin
          fork
            send_word(port, 32);
          join_none
        end
      end
      wait fork;
      drain_fifo();
    end

    // transmit words, then a transfer with nothing pending
    set_enables('1);
    for (int q = 0; q < NP; q++) begin
      w = $urandom;
      apb_write(spi_hub_pkg::ADDR_TX_BASE + spi_hub_pkg::APB_ADDR_W'(4 * q), w);
      m_tx[q]   = w;
      m_pend[q] = 1'b1;
      apb_read(spi_hub_pkg::ADDR_STATUS, data, err);
      check(data, exp_status(), "STATUS with tx word pending");
      send_word(q, 32);
      drain_fifo();
      send_word(q, 32);
      drain_fifo();
    end

    // frames cut short by ssel
    for (int k = 0; k < N_CUT; k++) begin
      p = $urandom_range(NP - 1);
      n = 1 + $urandom_range(30);
      send_word(p, n);
      send_word(p, 32);
      drain_fifo();
    end

    // back-pressure on port 0 until it overruns
    set_enables(32'h1);
    repeat (N_BP) send_word(0, 32);
    drain_fifo();
    apb_write(spi_hub_pkg::ADDR_STATUS, 32'h1 << spi_hub_pkg::STAT_OVR_LSB);
    m_ovr[0] = 1'b0;
    apb_read(spi_hub_pkg::ADDR_STATUS, data, err);
    check(data, exp_status(), "STATUS after overrun clear");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- compile.f
source/spi_hub_pkg.sv
source/spi_slave_port.sv
source/spi_apb_regs.sv
source/spi_rx_collector.sv
source/spi_hub.sv
sim/spi_hub_tb.sv

//--- Bender.yml
package:
  name: spi_hub

sources:
  - source/spi_hub_pkg.sv
  - source/spi_slave_port.sv
  - source/spi_apb_regs.sv
  - source/spi_rx_collector.sv
  - source/spi_hub.sv
  - target: test
    files:
      - sim/spi_hub_tb.sv
